//--- src/core_bus_pkg.sv
package core_bus_pkg;

  localparam int xlen = 32;

  // AXI ids of the two clients
  localparam logic [3:0] id_ifetch = 4'd1;
  localparam logic [3:0] id_data   = 4'd2;

  // mtime words, served locally
  localparam logic [31:0] timer_addr_lo = 32'h0200_bff8;
  localparam logic [31:0] timer_addr_hi = 32'h0200_bffc;

  // sdram window, inclusive on both ends
  localparam logic [31:0] burst_base  = 32'ha000_0000;
  localparam logic [31:0] burst_limit = 32'hc000_0000;

  localparam logic burst_fetch_enable = 1'b1;  // two-beat fetches in the window

  // axsize
  localparam logic [2:0] size_byte = 3'd0;
  localparam logic [2:0] size_half = 3'd1;
  localparam logic [2:0] size_word = 3'd2;

  // axburst
  localparam logic [1:0] burst_fixed = 2'b00;
  localparam logic [1:0] burst_incr  = 2'b01;

  localparam logic [1:0] resp_okay = 2'b00;

endpackage

//--- src/bus_read_arbiter.sv
`timescale 1ns/1ps

module bus_read_arbiter (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          ifetch_arvalid,
  input  logic [core_bus_pkg::xlen-1:0] ifetch_araddr,
  input  logic                          data_arvalid,
  input  logic [core_bus_pkg::xlen-1:0] data_araddr,
  input  logic [3:0]                    data_rstrb,
  input  logic                          axi_arready,
  input  logic [3:0]                    axi_rid,
  input  logic [core_bus_pkg::xlen-1:0] axi_rdata,
  input  logic [1:0]                    axi_rresp,
  input  logic                          axi_rlast,
  input  logic                          axi_rvalid,
  input  logic [core_bus_pkg::xlen-1:0] timer_rdata,
  output logic                          ifetch_grant,
  output logic                          ifetch_rvalid,
  output logic                          ifetch_rlast,
  output logic [core_bus_pkg::xlen-1:0] ifetch_rdata,
  output logic                          data_grant,
  output logic                          data_rvalid,
  output logic [core_bus_pkg::xlen-1:0] data_rdata,
  output logic [3:0]                    axi_arid,
  output logic [core_bus_pkg::xlen-1:0] axi_araddr,
  output logic [7:0]                    axi_arlen,
  output logic [2:0]                    axi_arsize,
  output logic [1:0]                    axi_arburst,
  output logic                          axi_arvalid,
  output logic                          axi_rready,
  output logic                          timer_read,
  output logic                          timer_sel
);

  logic                          ar_pending;     // address phase
  logic                          r_pending;      // data phase, until rlast
  logic                          timer_pending;  // timer word comes back now
  logic                          idle;
  logic                          data_is_timer;
  logic                          ifetch_burst;
  logic [2:0]                    data_size;
  logic                          rid_ifetch;
  logic                          rid_data;
  logic [core_bus_pkg::xlen-1:0] araddr_q;
  logic [3:0]                    arid_q;
  logic [2:0]                    arsize_q;
  logic                          burst_q;

  assign idle = !ar_pending && !r_pending && !timer_pending;

  assign data_is_timer = (data_araddr == core_bus_pkg::timer_addr_lo) ||
                         (data_araddr == core_bus_pkg::timer_addr_hi);

  assign ifetch_burst = core_bus_pkg::burst_fetch_enable &&
                        (ifetch_araddr >= core_bus_pkg::burst_base) &&
                        (ifetch_araddr <= core_bus_pkg::burst_limit);

  always_comb begin
    case (data_rstrb)
      4'b0001: data_size = core_bus_pkg::size_byte;
      4'b0011: data_size = core_bus_pkg::size_half;
      default: data_size = core_bus_pkg::size_word;
    endcase
  end

  // data port wins a tie
  assign data_grant   = idle && data_arvalid;
  assign ifetch_grant = idle && ifetch_arvalid && !data_arvalid;

  assign timer_read = data_grant && data_is_timer;
  assign timer_sel  = (data_araddr == core_bus_pkg::timer_addr_hi);

  always_ff @(posedge clock) begin
    if (reset) begin
      ar_pending    <= 1'b0;
      r_pending     <= 1'b0;
      timer_pending <= 1'b0;
    end else begin
      timer_pending <= timer_read;
      if (data_grant || ifetch_grant) begin
        ar_pending <= !timer_read;  // no AR for the timer
      end else if (ar_pending && axi_arready) begin
        ar_pending <= 1'b0;
        r_pending  <= 1'b1;
      end else if (r_pending && axi_rvalid && axi_rlast) begin
        r_pending <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (data_grant) begin
      araddr_q <= data_araddr;
      arid_q   <= core_bus_pkg::id_data;
      arsize_q <= data_size;
      burst_q  <= 1'b0;
    end else if (ifetch_grant) begin
      araddr_q <= ifetch_araddr;
      arid_q   <= core_bus_pkg::id_ifetch;
      arsize_q <= core_bus_pkg::size_word;  // fetches are whole words
      burst_q  <= ifetch_burst;
    end
  end

  assign axi_arid    = arid_q;
  assign axi_araddr  = araddr_q;
  assign axi_arsize  = arsize_q;
  assign axi_arlen   = burst_q ? 8'd1 : 8'd0;
  assign axi_arburst = burst_q ? core_bus_pkg::burst_incr : core_bus_pkg::burst_fixed;
  assign axi_arvalid = ar_pending;
  assign axi_rready  = 1'b1;

  // route beats by id
  assign rid_ifetch = (axi_rid == core_bus_pkg::id_ifetch);
  assign rid_data   = (axi_rid == core_bus_pkg::id_data);

  assign ifetch_rvalid = axi_rvalid && rid_ifetch;
  assign ifetch_rlast  = ifetch_rvalid && axi_rlast;
  assign ifetch_rdata  = axi_rdata;

  assign data_rvalid = (axi_rvalid && rid_data) || timer_pending;
  assign data_rdata  = timer_pending ? timer_rdata : axi_rdata;

  rresp_okay_a: assert property (@(posedge clock) disable iff (reset)
    axi_rvalid |-> axi_rresp == core_bus_pkg::resp_okay)
    else $error("rresp not OKAY");

  // address held until the slave takes it
  araddr_stable_a: assert property (@(posedge clock) disable iff (reset)
    axi_arvalid && !axi_arready |=> axi_arvalid && $stable(axi_araddr))
    else $error("AR payload changed while waiting");

endmodule

//--- src/bus_store_engine.sv
`timescale 1ns/1ps

module bus_store_engine (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          data_awvalid,
  input  logic [core_bus_pkg::xlen-1:0] data_awaddr,
  input  logic                          data_wvalid,
  input  logic [core_bus_pkg::xlen-1:0] data_wdata,
  input  logic [3:0]                    data_wstrb,
  input  logic                          axi_awready,
  input  logic                          axi_wready,
  input  logic                          axi_bvalid,
  input  logic [1:0]                    axi_bresp,
  output logic                          data_store_done,
  output logic [core_bus_pkg::xlen-1:0] axi_awaddr,
  output logic [2:0]                    axi_awsize,
  output logic                          axi_awvalid,
  output logic [core_bus_pkg::xlen-1:0] axi_wdata,
  output logic [3:0]                    axi_wstrb,
  output logic                          axi_wlast,
  output logic                          axi_wvalid,
  output logic                          axi_bready
);

  logic                          wait_b;   // both phases done, waiting on B
  logic                          aw_done;
  logic                          w_done;
  logic                          aw_fire;
  logic                          w_fire;
  logic [1:0]                    lane;
  logic [core_bus_pkg::xlen-1:0] aw_word_addr;

  assign lane = data_awaddr[1:0];

  // move data and strobe up to the addressed byte lanes
  assign axi_awaddr = data_awaddr;
  assign axi_wdata  = data_wdata << {lane, 3'b000};
  assign axi_wstrb  = data_wstrb << lane;

  // size from the strobe as the client gave it
  always_comb begin
    case (data_wstrb)
      4'b0001: axi_awsize = core_bus_pkg::size_byte;
      4'b0011: axi_awsize = core_bus_pkg::size_half;
      default: axi_awsize = core_bus_pkg::size_word;
    endcase
  end

  assign axi_awvalid = !wait_b && data_awvalid && !aw_done;
  assign axi_wvalid  = !wait_b && data_wvalid && !w_done;
  assign axi_wlast   = axi_wvalid;  // single beat
  assign axi_bready  = wait_b;

  assign aw_fire = axi_awvalid && axi_awready;
  assign w_fire  = axi_wvalid && axi_wready;

  assign data_store_done = axi_bvalid && wait_b;

  always_ff @(posedge clock) begin
    if (reset) begin
      wait_b  <= 1'b0;
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end else if (wait_b) begin
      if (axi_bvalid) begin
        wait_b  <= 1'b0;
        aw_done <= 1'b0;
        w_done  <= 1'b0;
      end
    end else begin
      // AW and W in either order
      if ((aw_done || aw_fire) && (w_done || w_fire)) begin
        wait_b <= 1'b1;
      end
      if (aw_fire) begin
        aw_done <= 1'b1;
      end
      if (w_fire) begin
        w_done <= 1'b1;
      end
    end
  end

  bresp_okay_a: assert property (@(posedge clock) disable iff (reset)
    axi_bvalid |-> axi_bresp == core_bus_pkg::resp_okay)
    else $error("bresp not OKAY");

  assign aw_word_addr = {axi_awaddr[core_bus_pkg::xlen-1:2], 2'b00};

  // timer is read-only through this bridge
  no_timer_store_a: assert property (@(posedge clock) disable iff (reset)
    axi_awvalid |-> aw_word_addr != core_bus_pkg::timer_addr_lo &&
                    aw_word_addr != core_bus_pkg::timer_addr_hi)
    else $error("store to timer address %h", axi_awaddr);

endmodule

//--- src/machine_timer.sv
`timescale 1ns/1ps

module machine_timer (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          read,
  input  logic                          sel,    // high word
  output logic [core_bus_pkg::xlen-1:0] rdata
);

  logic [2*core_bus_pkg::xlen-1:0] mtime;

  always_ff @(posedge clock) begin
    if (reset) begin
      mtime <= '0;
    end else begin
      mtime <= mtime + 1'b1;  // one tick per cycle
    end
  end

  // sampled at the grant edge
  always_ff @(posedge clock) begin
    if (read) begin
      if (sel) begin
        rdata <= mtime[2*core_bus_pkg::xlen-1:core_bus_pkg::xlen];
      end else begin
        rdata <= mtime[core_bus_pkg::xlen-1:0];
      end
    end
  end

  // arbiter spends a cycle returning each timer word
  read_spaced_a: assert property (@(posedge clock) disable iff (reset)
    read |=> !read)
    else $error("back-to-back timer reads");

endmodule

//--- src/core_bus_top.sv
`timescale 1ns/1ps

module core_bus_top (
  input  logic                          clock,
  input  logic                          reset,
  // fetch client
  input  logic                          ifetch_arvalid,
  input  logic [core_bus_pkg::xlen-1:0] ifetch_araddr,
  output logic                          ifetch_grant,
  output logic                          ifetch_rvalid,
  output logic                          ifetch_rlast,
  output logic [core_bus_pkg::xlen-1:0] ifetch_rdata,
  // data client
  input  logic                          data_arvalid,
  input  logic [core_bus_pkg::xlen-1:0] data_araddr,
  input  logic [3:0]                    data_rstrb,
  output logic                          data_grant,
  output logic                          data_rvalid,
  output logic [core_bus_pkg::xlen-1:0] data_rdata,
  input  logic                          data_awvalid,
  input  logic [core_bus_pkg::xlen-1:0] data_awaddr,
  input  logic                          data_wvalid,
  input  logic [core_bus_pkg::xlen-1:0] data_wdata,
  input  logic [3:0]                    data_wstrb,
  output logic                          data_store_done,
  // AXI4 master
  output logic [3:0]                    axi_arid,
  output logic [core_bus_pkg::xlen-1:0] axi_araddr,
  output logic [7:0]                    axi_arlen,
  output logic [2:0]                    axi_arsize,
  output logic [1:0]                    axi_arburst,
  output logic                          axi_arvalid,
  input  logic                          axi_arready,
  input  logic [3:0]                    axi_rid,
  input  logic [core_bus_pkg::xlen-1:0] axi_rdata,
  input  logic [1:0]                    axi_rresp,
  input  logic                          axi_rlast,
  input  logic                          axi_rvalid,
  output logic                          axi_rready,
  output logic [3:0]                    axi_awid,
  output logic [core_bus_pkg::xlen-1:0] axi_awaddr,
  output logic [7:0]                    axi_awlen,
  output logic [2:0]                    axi_awsize,
  output logic                          axi_awvalid,
  input  logic                          axi_awready,
  output logic [core_bus_pkg::xlen-1:0] axi_wdata,
  output logic [3:0]                    axi_wstrb,
  output logic                          axi_wlast,
  output logic                          axi_wvalid,
  input  logic                          axi_wready,
  input  logic [1:0]                    axi_bresp,
  input  logic                          axi_bvalid,
  output logic                          axi_bready
);

  logic                          timer_read;
  logic                          timer_sel;
  logic [core_bus_pkg::xlen-1:0] timer_rdata;

  // only the data port stores, one beat each
  assign axi_awid  = core_bus_pkg::id_data;
  assign axi_awlen = 8'd0;

  bus_read_arbiter read_arbiter_i (
    .clock          (clock),
    .reset          (reset),
    .ifetch_arvalid (ifetch_arvalid),
    .ifetch_araddr  (ifetch_araddr),
    .data_arvalid   (data_arvalid),
    .data_araddr    (data_araddr),
    .data_rstrb     (data_rstrb),
    .axi_arready    (axi_arready),
    .axi_rid        (axi_rid),
    .axi_rdata      (axi_rdata),
    .axi_rresp      (axi_rresp),
    .axi_rlast      (axi_rlast),
    .axi_rvalid     (axi_rvalid),
    .timer_rdata    (timer_rdata),
    .ifetch_grant   (ifetch_grant),
    .ifetch_rvalid  (ifetch_rvalid),
    .ifetch_rlast   (ifetch_rlast),
    .ifetch_rdata   (ifetch_rdata),
    .data_grant     (data_grant),
    .data_rvalid    (data_rvalid),
    .data_rdata     (data_rdata),
    .axi_arid       (axi_arid),
    .axi_araddr     (axi_araddr),
    .axi_arlen      (axi_arlen),
    .axi_arsize     (axi_arsize),
    .axi_arburst    (axi_arburst),
    .axi_arvalid    (axi_arvalid),
    .axi_rready     (axi_rready),
    .timer_read     (timer_read),
    .timer_sel      (timer_sel)
  );

  bus_store_engine store_engine_i (
    .clock           (clock),
    .reset           (reset),
    .data_awvalid    (data_awvalid),
    .data_awaddr     (data_awaddr),
    .data_wvalid     (data_wvalid),
    .data_wdata      (data_wdata),
    .data_wstrb      (data_wstrb),
    .axi_awready     (axi_awready),
    .axi_wready      (axi_wready),
    .axi_bvalid      (axi_bvalid),
    .axi_bresp       (axi_bresp),
    .data_store_done (data_store_done),
    .axi_awaddr      (axi_awaddr),
    .axi_awsize      (axi_awsize),
    .axi_awvalid     (axi_awvalid),
    .axi_wdata       (axi_wdata),
    .axi_wstrb       (axi_wstrb),
    .axi_wlast       (axi_wlast),
    .axi_wvalid      (axi_wvalid),
    .axi_bready      (axi_bready)
  );

  machine_timer timer_i (
    .clock (clock),
    .reset (reset),
    .read  (timer_read),
    .sel   (timer_sel),
    .rdata (timer_rdata)
  );

endmodule

//--- tests/axi_mem_model.sv
`timescale 1ns/1ps

module axi_mem_model (
  input  logic        clock, reset,
  input  logic [3:0]  axi_arid,
  input  logic [31:0] axi_araddr, axi_awaddr, axi_wdata,
  input  logic [7:0]  axi_arlen,
  input  logic [3:0]  axi_wstrb,
  input  logic        axi_arvalid, axi_awvalid, axi_wvalid, axi_bready,
  output logic        axi_arready, axi_rvalid, axi_rlast,
  output logic        axi_awready, axi_wready, axi_bvalid,
  output logic [3:0]  axi_rid,
  output logic [31:0] axi_rdata,
  output logic [1:0]  axi_rresp, axi_bresp
);

  logic [31:0] words [0:1023];  // 4 KiB, mirrored
  bit          written [0:1023];

  // unwritten words read back as the inverted byte address
  function automatic logic [31:0] word_at(input logic [31:0] addr);
    if (written[addr[11:2]]) begin
      return words[addr[11:2]];
    end
    return ~{addr[31:2], 2'b00};
  endfunction

  task automatic skip_cycles(input int n);
    repeat (n) begin
      @(posedge clock);
      #1;
    end
  endtask

  task automatic serve_reads();
    logic [3:0]  id;
    logic [31:0] addr;
    logic [7:0]  len;
    forever begin
      @(posedge clock);
      if (!reset && axi_arvalid) begin
        #1;
        skip_cycles($urandom_range(3, 0));
        axi_arready = 1'b1;
        id   = axi_arid;
        addr = {axi_araddr[31:2], 2'b00};
        len  = axi_arlen;
        @(posedge clock);
        #1;
        axi_arready = 1'b0;
        for (int beat = 0; beat <= int'(len); beat++) begin
          skip_cycles($urandom_range(3, 0));
          axi_rvalid = 1'b1;
          axi_rid    = id;
          axi_rdata  = word_at(addr + 4 * beat);  // incr burst
          axi_rlast  = (beat == int'(len));
          @(posedge clock);  // rready tied high
          #1;
          axi_rvalid = 1'b0;
          axi_rlast  = 1'b0;
        end
      end
    end
  endtask

  task automatic serve_writes();
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] merged;
    logic [3:0]  strb;
    int          aw_wait;
    int          w_wait;
    forever begin
      @(posedge clock);
      if (!reset && axi_awvalid && axi_wvalid) begin
        #1;
        addr    = axi_awaddr;
        data    = axi_wdata;
        strb    = axi_wstrb;
        aw_wait = $urandom_range(3, 0);
        w_wait  = $urandom_range(3, 0);
        // separate delays so AW and W finish in either order
        for (int t = 0; t <= 3; t++) begin
          axi_awready = (t == aw_wait);
          axi_wready  = (t == w_wait);
          @(posedge clock);
          #1;
        end
        axi_awready = 1'b0;
        axi_wready  = 1'b0;
        merged = word_at(addr);
        for (int i = 0; i < 4; i++) begin
          if (strb[i]) begin
            merged[8*i +: 8] = data[8*i +: 8];
          end
        end
        words[addr[11:2]]   = merged;
        written[addr[11:2]] = 1'b1;
        skip_cycles($urandom_range(3, 0));
        axi_bvalid = 1'b1;
        do begin
          @(posedge clock);
        end while (!axi_bready);
        #1;
        axi_bvalid = 1'b0;
      end
    end
  endtask

  initial begin
    void'($urandom(57));
    axi_arready = 1'b0;
    axi_rvalid  = 1'b0;
    axi_rlast   = 1'b0;
    axi_rid     = 4'd0;
    axi_rdata   = 32'd0;
    axi_rresp   = 2'b00;
    axi_awready = 1'b0;
    axi_wready  = 1'b0;
    axi_bvalid  = 1'b0;
    axi_bresp   = 2'b00;
    fork
      serve_reads();
      serve_writes();
    join
  end

endmodule

//--- tests/core_bus_tb.sv
`timescale 1ns/1ps

module core_bus_tb;

  localparam int num_tests       = 5;
  localparam int cycles_per_test = 200;
  localparam int period_ns       = 4;

  logic        clock, reset;
  logic        ifetch_arvalid, ifetch_grant, ifetch_rvalid, ifetch_rlast;
  logic        data_arvalid, data_grant, data_rvalid;
  logic        data_awvalid, data_wvalid, data_store_done;
  logic [31:0] ifetch_araddr, ifetch_rdata, data_araddr, data_rdata;
  logic [31:0] data_awaddr, data_wdata;
  logic [3:0]  data_rstrb, data_wstrb;
  logic [3:0]  axi_arid, axi_rid, axi_awid, axi_wstrb;
  logic [31:0] axi_araddr, axi_rdata, axi_awaddr, axi_wdata;
  logic [7:0]  axi_arlen, axi_awlen;
  logic [2:0]  axi_arsize, axi_awsize;
  logic [1:0]  axi_arburst, axi_rresp, axi_bresp;
  logic        axi_arvalid, axi_arready, axi_rlast, axi_rvalid, axi_rready;
  logic        axi_awvalid, axi_awready, axi_wlast, axi_wvalid, axi_wready;
  logic        axi_bvalid, axi_bready;

  int          errors     = 0;
  int          tests_done = 0;
  int          cycle      = 0;
  logic [31:0] shadow [logic [31:0]];  // words written so far
  logic        busy, fetch_burst, timer_rd_q, have_prev_timer, store_active;
  int          fetch_left, timer_grant_cycle, prev_grant_cycle;
  logic [31:0] fetch_exp, fetch_exp_next, data_exp, prev_timer_val;
  logic [31:0] exp_araddr, exp_awaddr, exp_wdata;
  logic [3:0]  exp_wstrb;
  logic [2:0]  exp_data_size, exp_awsize;

  core_bus_top core_bus_top_i (.*);
  axi_mem_model mem (.*);

  function automatic logic [31:0] expected_word(input logic [31:0] addr);
    logic [31:0] aligned;
    aligned = {addr[31:2], 2'b00};
    if (shadow.exists(aligned)) begin
      return shadow[aligned];
    end
    return ~aligned;
  endfunction

  function automatic logic [2:0] size_for(input logic [3:0] strb);
    case (strb)
      4'b0001: return core_bus_pkg::size_byte;
      4'b0011: return core_bus_pkg::size_half;
      default: return core_bus_pkg::size_word;
    endcase
  endfunction

  task automatic note_failure(input string msg);
    errors++;
    $display("FAIL %0t ns: %s", $time, msg);
  endtask

  // expected state of the bridge, followed from the requests
  always @(posedge clock) begin
    cycle <= cycle + 1;
    if (reset) begin
      busy            <= 1'b0;
      timer_rd_q      <= 1'b0;
      have_prev_timer <= 1'b0;
      fetch_left      <= 0;
    end else begin
      timer_rd_q <= data_grant && (data_araddr == core_bus_pkg::timer_addr_lo ||
                                   data_araddr == core_bus_pkg::timer_addr_hi);
      if (data_grant || ifetch_grant) begin
        busy <= 1'b1;
      end else if ((ifetch_rvalid && fetch_left == 1) || data_rvalid) begin
        busy <= 1'b0;
      end
      if (ifetch_grant) begin
        fetch_left     <= fetch_burst ? 2 : 1;
        fetch_exp      <= expected_word(ifetch_araddr);
        fetch_exp_next <= expected_word(ifetch_araddr + 32'd4);
        exp_araddr     <= ifetch_araddr;
      end else if (ifetch_rvalid) begin
        fetch_left <= fetch_left - 1;
        fetch_exp  <= fetch_exp_next;
      end
      if (data_grant) begin
        data_exp          <= expected_word(data_araddr);
        exp_data_size     <= size_for(data_rstrb);
        exp_araddr        <= data_araddr;
        timer_grant_cycle <= cycle;
      end
      if (timer_rd_q) begin
        prev_timer_val   <= data_rdata;
        prev_grant_cycle <= timer_grant_cycle;
        have_prev_timer  <= 1'b1;
      end
    end
  end

  fetch_data_a: assert property (@(posedge clock) disable iff (reset)
    ifetch_rvalid |-> ifetch_rdata == fetch_exp && ifetch_rlast == (fetch_left == 1))
    else note_failure("fetch beat data or rlast wrong");

  fetch_ar_a: assert property (@(posedge clock) disable iff (reset)
    axi_arvalid && axi_arid == core_bus_pkg::id_ifetch |->
      axi_arsize == core_bus_pkg::size_word && axi_arlen == (fetch_burst ? 8'd1 : 8'd0) &&
      (!fetch_burst || axi_arburst == core_bus_pkg::burst_incr))
    else note_failure("fetch AR size, len or burst wrong");

  data_ar_a: assert property (@(posedge clock) disable iff (reset)
    axi_arvalid && axi_arid == core_bus_pkg::id_data |->
      axi_arsize == exp_data_size && axi_arlen == 8'd0)
    else note_failure("data AR size or len wrong");

  ar_addr_a: assert property (@(posedge clock) disable iff (reset)
    axi_arvalid |-> axi_araddr == exp_araddr)
    else note_failure("AR address wrong");

  rready_a: assert property (@(posedge clock) disable iff (reset)
    axi_rready)
    else note_failure("rready dropped");

  data_read_a: assert property (@(posedge clock) disable iff (reset)
    data_rvalid && !timer_rd_q |-> data_rdata == data_exp)
    else note_failure("data read word wrong");

  grant_order_a: assert property (@(posedge clock) disable iff (reset)
    (data_grant || ifetch_grant) |-> !busy && !(ifetch_grant && data_arvalid))
    else note_failure("grant while busy or fetch granted over data");

  timer_latency_a: assert property (@(posedge clock) disable iff (reset)
    timer_rd_q |-> data_rvalid && !axi_arvalid)
    else note_failure("timer word late or AR raised");

  timer_delta_a: assert property (@(posedge clock) disable iff (reset)
    timer_rd_q && have_prev_timer |->
      data_rdata - prev_timer_val == 32'(timer_grant_cycle - prev_grant_cycle))
    else note_failure("timer delta does not match grant spacing");

  store_lanes_a: assert property (@(posedge clock) disable iff (reset)
    axi_wvalid |-> axi_wdata == exp_wdata && axi_wstrb == exp_wstrb && axi_wlast)
    else note_failure("W data, strobe or wlast wrong");

  store_addr_a: assert property (@(posedge clock) disable iff (reset)
    axi_awvalid |-> axi_awaddr == exp_awaddr && axi_awsize == exp_awsize &&
      axi_awid == core_bus_pkg::id_data && axi_awlen == 8'd0)
    else note_failure("AW address, id, len or size wrong");

  store_done_a: assert property (@(posedge clock) disable iff (reset)
    data_store_done |-> axi_bready && store_active ##1 !data_store_done)
    else note_failure("store done pulse unexpected or too long");

  task automatic fetch(input logic [31:0] addr, input logic burst);
    fetch_burst    = burst;  // two beats expected
    ifetch_arvalid = 1'b1;
    ifetch_araddr  = addr;
    do begin
      @(posedge clock);
    end while (!ifetch_grant);
    #1;
    ifetch_arvalid = 1'b0;
    do begin
      @(posedge clock);
    end while (!(ifetch_rvalid && ifetch_rlast));
    #1;
  endtask

  task automatic data_read(input logic [31:0] addr, input logic [3:0] strb);
    data_arvalid = 1'b1;
    data_araddr  = addr;
    data_rstrb   = strb;
    do begin
      @(posedge clock);
    end while (!data_grant);
    #1;
    data_arvalid = 1'b0;
    do begin
      @(posedge clock);
    end while (!data_rvalid);
    #1;
  endtask

  task automatic store(input logic [31:0] addr, input logic [31:0] data,
                       input logic [3:0] strb, input logic [31:0] lane_data,
                       input logic [3:0] lane_strb);
    logic [31:0] word;
    exp_awaddr   = addr;
    exp_awsize   = size_for(strb);
    exp_wstrb    = lane_strb;
    exp_wdata    = lane_data;
    store_active = 1'b1;
    data_awvalid = 1'b1;
    data_wvalid  = 1'b1;
    data_awaddr  = addr;
    data_wdata   = data;
    data_wstrb   = strb;
    do begin
      @(posedge clock);
    end while (!data_store_done);
    word = expected_word(addr);
    for (int i = 0; i < 4; i++) begin
      if (exp_wstrb[i]) begin
        word[8*i +: 8] = exp_wdata[8*i +: 8];
      end
    end
    shadow[{addr[31:2], 2'b00}] = word;
    #1;
    data_awvalid = 1'b0;
    data_wvalid  = 1'b0;
    store_active = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clock);
      #1;
    end
  endtask

  task automatic finish_test(input string name);
    tests_done++;
    $display("test %0d %s done, errors so far %0d", tests_done, name, errors);
  endtask

  initial begin
    clock = 1'b0;
    forever #(period_ns / 2) clock = ~clock;
  end

  initial begin
    #(num_tests * cycles_per_test * period_ns);
    $display("timeout: tests still running after %0d cycles", num_tests * cycles_per_test);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    reset          = 1'b1;
    ifetch_arvalid = 1'b0;
    ifetch_araddr  = 32'd0;
    data_arvalid   = 1'b0;
    data_araddr    = 32'd0;
    data_rstrb     = 4'd0;
    data_awvalid   = 1'b0;
    data_awaddr    = 32'd0;
    data_wvalid    = 1'b0;
    data_wdata     = 32'd0;
    data_wstrb     = 4'd0;
    store_active   = 1'b0;
    fetch_burst    = 1'b0;
    repeat (4) @(posedge clock);
    #1;
    reset = 1'b0;

    fetch(32'h0000_0100, 1'b0);
    finish_test("single fetch");
    fetch(32'ha000_0040, 1'b1);
    finish_test("burst fetch");
    ifetch_arvalid = 1'b1;  // both ask in the same cycle
    ifetch_araddr  = 32'h0000_0200;
    data_read(32'h0000_0301, 4'b0001);
    fetch(32'h0000_0200, 1'b0);
    data_read(32'h0000_0402, 4'b0011);
    finish_test("arbitration and read sizes");
    store(32'h0000_0501, 32'h0000_00a5, 4'b0001, 32'h0000_a500, 4'b0010);  // lane 1
    store(32'h0000_0502, 32'h0000_5a3c, 4'b0011, 32'h5a3c_0000, 4'b1100);  // lanes 2 and 3
    data_read(32'h0000_0500, 4'b1111);
    finish_test("byte and half stores");
    data_read(core_bus_pkg::timer_addr_lo, 4'b1111);
    idle_cycles(7);
    data_read(core_bus_pkg::timer_addr_lo, 4'b1111);
    finish_test("timer reads");

    $display("tests run %0d, errors %0d", tests_done, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- vlog.f
src/core_bus_pkg.sv
src/bus_read_arbiter.sv
src/bus_store_engine.sv
src/machine_timer.sv
src/core_bus_top.sv
tests/axi_mem_model.sv
tests/core_bus_tb.sv
